// File: Makefile
VERILATOR := verilator
TOP       := armCtrlTb
FILELIST  := list.f
BUILD_DIR := obj_dir
VFLAGS    := --binary -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/armCtrlTb.sv
`timescale 1ns/1ps

module armCtrlTb;

  localparam int    clkPeriod    = 4;
  localparam int    resetCycles  = 3;
  localparam int    maxRows      = 64;
  localparam int    numOutputs   = 11;
  localparam int    numFields    = 16;   // 5 stimulus + 11 expected
  localparam int    memToRegWCol = 9;    // Expected memToRegW column
  localparam int    seed         = 78959;
  localparam string vectorPath   = "bench/ctrlVectors.txt";

  // DUT stimulus
  logic        clk;
  logic        rstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  addrLowE;
  logic        stallE, stallM, stallW;
  logic        flushE, flushM, flushW;
  // DUT responses
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic        branchTakenE;
  logic [3:0]  flagsE;
  logic        memWriteM;
  logic        memToRegM;   // Checked against next row's memToRegW
  logic [3:0]  byteMaskM;
  logic        regWriteW;
  logic        memToRegW;
  logic        pcSrcW;

  // ========================================
  // Vector storage
  // ========================================
  logic [31:0] instrVec    [maxRows];
  logic [3:0]  flagsVec    [maxRows];
  bit          randomFlags [maxRows];  // Row marked x, ALU flags are don't care
  logic [1:0]  addrVec     [maxRows];
  logic [2:0]  stallVec    [maxRows];  // {E, M, W}
  logic [2:0]  flushVec    [maxRows];  // {E, M, W}
  logic [31:0] expVec      [maxRows][numOutputs];

  string outNames [numOutputs] = '{"regSrcD", "immSrcD", "aluSrcE", "aluControlE",
                                   "branchTakenE", "flagsE", "memWriteM", "byteMaskM",
                                   "regWriteW", "memToRegW", "pcSrcW"};

  int          rowCount;
  int          rowIdx;      // -1 while in reset
  int          errorCount;
  int          checkCount;
  int          cycleCount;
  int          cycleLimit;

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  armCtrl i_armCtrl (.*);

  // Run limit, vectors plus reset plus slack
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch %s row %0d: got 0x%h, expected 0x%h",
               name, rowIdx, actual, expected);
    end
  endtask

  // Outputs by column index, zero extended
  function automatic logic [31:0] outputValue(input int idx);
    logic [31:0] value;
    case (idx)
      0:       value = {30'b0, regSrcD};
      1:       value = {30'b0, immSrcD};
      2:       value = {31'b0, aluSrcE};
      3:       value = {28'b0, aluControlE};
      4:       value = {31'b0, branchTakenE};
      5:       value = {28'b0, flagsE};
      6:       value = {31'b0, memWriteM};
      7:       value = {28'b0, byteMaskM};
      8:       value = {31'b0, regWriteW};
      9:       value = {31'b0, memToRegW};
      default: value = {31'b0, pcSrcW};
    endcase
    return value;
  endfunction

  // ========================================
  // Vector file parsing
  // ========================================
  task automatic loadVectors();
    int          fd;
    int          got;
    int          i;
    string       line;
    string       flagTok;
    logic [31:0] field [numFields];
    fd = $fopen(vectorPath, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", vectorPath);
      errorCount++;
    end else begin
      while (!$feof(fd) && rowCount < maxRows) begin
        line     = "";
        field[1] = '0;
        void'($fgets(line, fd));
        // Blank lines and # lines carry no data
        if (line.len() > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%h %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        field[0], flagTok, field[2], field[3], field[4], field[5],
                        field[6], field[7], field[8], field[9], field[10], field[11],
                        field[12], field[13], field[14], field[15]);
          if (got != numFields) begin
            $display("Vector line after row %0d has missing fields and is skipped", rowCount);
            errorCount++;
          end else begin
            randomFlags[rowCount] = (flagTok == "x");
            if (!randomFlags[rowCount]) begin
              void'($sscanf(flagTok, "%h", field[1]));
            end
            instrVec[rowCount] = field[0];
            flagsVec[rowCount] = field[1][3:0];
            addrVec[rowCount]  = field[2][1:0];
            stallVec[rowCount] = field[3][2:0];
            flushVec[rowCount] = field[4][2:0];
            for (i = 0; i < numOutputs; i++) begin
              expVec[rowCount][i] = field[i + 5];
            end
            rowCount++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic applyRow(input int r);
    logic [31:0] randWord;
    randWord  = $urandom();
    instrD    = instrVec[r];
    aluFlagsE = randomFlags[r] ? randWord[3:0] : flagsVec[r];
    addrLowE  = addrVec[r];
    {stallE, stallM, stallW} = stallVec[r];
    {flushE, flushM, flushW} = flushVec[r];
  endtask

  // All zero in reset, else the row's expected columns
  task automatic checkOutputs();
    int i;
    for (i = 0; i < numOutputs; i++) begin
      if (rowIdx < 0) begin
        checkValue(outNames[i], outputValue(i), '0);
      end else begin
        checkValue(outNames[i], outputValue(i), expVec[rowIdx][i]);
      end
    end
    // Memory stage load flag shows up in Writeback one edge later unless W holds or drops it
    if (rowIdx < 0) begin
      checkValue("memToRegM", {31'b0, memToRegM}, '0);
    end else if (rowIdx + 1 < rowCount && !stallVec[rowIdx + 1][0] &&
                 !flushVec[rowIdx + 1][0]) begin
      checkValue("memToRegM", {31'b0, memToRegM}, expVec[rowIdx + 1][memToRegWCol]);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    void'($urandom(seed));
    rstN       = 1'b0;
    instrD     = '0;
    aluFlagsE  = '0;
    addrLowE   = '0;
    {stallE, stallM, stallW} = 3'b000;
    {flushE, flushM, flushW} = 3'b000;
    rowCount   = 0;
    errorCount = 0;
    checkCount = 0;
    loadVectors();
    cycleLimit = rowCount + resetCycles + 10;
    rowIdx     = -1;

    repeat (resetCycles) begin
      @(posedge clk);
      #1;                              // Registers settled after the edge
      checkOutputs();
    end

    // Drive on falling edge, check just before the next one
    for (rowIdx = 0; rowIdx < rowCount; rowIdx++) begin
      @(negedge clk);
      rstN = 1'b1;
      applyRow(rowIdx);
      @(posedge clk);
      #1;
      checkOutputs();
    end

    if (rowCount == 0) begin
      $display("No vector rows were read, nothing was tested");
      errorCount++;
    end
    $display("Finished: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: bench/ctrlVectors.txt
# instr aluFlagsE(x random) addrLowE stall{EMW} flush{EMW} | regSrcD immSrcD aluSrcE aluControlE
# branchTakenE flagsE memWriteM byteMaskM regWriteW memToRegW pcSrcW; aluFlags/addrLow go with prev row
EC000000 x 0 0 0  0 0 0 0 0 0 0 0 0 0 0  # undef, right after reset
E2821005 x 0 0 0  0 0 1 4 0 0 0 0 0 0 0  # ADD r1, r2, #5
E1843005 x 0 0 0  0 0 0 C 0 0 0 0 0 0 0  # ORR r3, r4, r5
E5910004 x 0 0 0  0 1 1 4 0 0 0 0 1 0 0  # LDR r0, [r1, #4]
E5012008 x 0 0 0  2 1 1 2 0 0 0 F 1 0 0  # STR r2, [r1, #-8]
EA000004 x 0 0 0  1 2 1 4 1 0 1 F 1 1 0  # B
E5C12001 x 0 0 0  2 1 1 4 0 0 0 0 0 0 0  # STRB
E5C12001 x 0 0 0  2 1 1 4 0 0 1 1 0 0 1  # STRB, lane 0
E5C12001 x 1 0 0  2 1 1 4 0 0 1 2 0 0 0  # STRB, lane 1
E5C12001 x 2 0 0  2 1 1 4 0 0 1 4 0 0 0  # STRB, lane 2
E591F000 x 3 0 0  0 1 1 4 0 0 1 8 0 0 0  # LDR pc, lane 3 for last STRB
EC000000 x 0 0 0  0 0 0 0 0 0 0 F 0 0 0  # undef
E3510000 x 0 0 0  0 0 1 A 0 0 0 0 1 1 1  # CMP r1, #0, pcSrcW from LDR pc
0A000002 4 0 0 0  1 2 1 4 1 4 0 0 0 0 0  # BEQ, Z forwarded from Memory
1A000002 x 0 0 0  1 2 1 4 0 4 0 0 0 0 0  # BNE, Z forwarded from Writeback
EC000000 x 0 0 0  0 0 0 0 0 4 0 0 0 0 1  # flags committed
15012008 x 0 0 0  2 1 1 2 0 4 0 0 0 0 0  # STRNE, killed
12821005 x 0 0 0  0 0 1 4 0 4 0 F 0 0 0  # ADDNE, killed
13510000 x 0 0 0  0 0 1 A 0 4 0 0 0 0 0  # CMPNE, killed
EC000000 1 0 0 0  0 0 0 0 0 4 0 0 0 0 0  # new ALU flags ignored
EC000000 x 0 0 0  0 0 0 0 0 4 0 0 0 0 0
E1843005 x 0 0 0  0 0 0 C 0 4 0 0 0 0 0  # ORR
E2821005 x 0 4 0  0 0 0 C 0 4 0 0 0 0 0  # stallE, ORR held in Execute
E2821005 x 0 0 0  0 0 1 4 0 4 0 0 1 0 0  # ADD released
E5012008 x 0 0 0  2 1 1 2 0 4 0 0 1 0 0  # STR
EC000000 x 0 0 2  0 0 0 0 0 4 0 0 1 0 0  # flushM drops the STR
EC000000 x 0 0 0  0 0 0 0 0 4 0 0 0 0 0

// File: list.f
src/isaPkg.sv
src/ctrlPkg.sv
src/instrDecoder.sv
src/stageReg.sv
src/condUnit.sv
src/executeCtrl.sv
src/statusReg.sv
src/armCtrl.sv
bench/armCtrlTb.sv

// File: src/armCtrl.sv
`timescale 1ns/1ps

module armCtrl (
  input  logic               clk,
  input  logic               rstN,
  // From datapath
  input  isaPkg::instrT      instrD,
  input  isaPkg::flagsT      aluFlagsE,
  input  logic [1:0]         addrLowE,
  // From hazard unit
  input  logic               stallE, stallM, stallW,
  input  logic               flushE, flushM, flushW,
  // Decode, combinational
  output ctrlPkg::regSrcT    regSrcD,
  output ctrlPkg::immSrcT    immSrcD,
  // Execute
  output logic               aluSrcE,
  output isaPkg::aluOpT      aluControlE,
  output logic               branchTakenE,
  output isaPkg::flagsT      flagsE,
  // Memory
  output logic               memWriteM,
  output logic               memToRegM,
  output ctrlPkg::byteMaskT  byteMaskM,
  // Writeback
  output logic               regWriteW,
  output logic               memToRegW,
  output logic               pcSrcW
);

  logic                 aluSrcD, branchD, memWriteD, memToRegD;
  logic                 regWriteD, pcWriteD, byteAccessD;
  isaPkg::aluOpT        aluControlD;
  ctrlPkg::flagWriteT   flagWriteD;
  ctrlPkg::execPayloadT execD, execE;
  ctrlPkg::memPayloadT  memE, memM;
  ctrlPkg::wbPayloadT   wbM, wbW;
  logic                 memWriteGatedE, regWriteGatedE, pcSrcGatedE, setFlagsE;
  isaPkg::flagsT        nextFlagsE;
  ctrlPkg::byteMaskT    byteMaskE;

  // ========================================
  // Decode
  // ========================================
  instrDecoder decoderD (
    .instrD      (instrD),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcD     (aluSrcD),
    .aluControlD (aluControlD),
    .flagWriteD  (flagWriteD),
    .branchD     (branchD),
    .memWriteD   (memWriteD),
    .memToRegD   (memToRegD),
    .regWriteD   (regWriteD),
    .pcWriteD    (pcWriteD),
    .byteAccessD (byteAccessD)
  );

  assign execD = '{aluSrc: aluSrcD, aluControl: aluControlD, flagWrite: flagWriteD,
                   branch: branchD, memWrite: memWriteD, memToReg: memToRegD,
                   regWrite: regWriteD, pcWrite: pcWriteD, byteAccess: byteAccessD,
                   cond: isaPkg::condT'(instrD[isaPkg::condField +: $bits(isaPkg::condT)])};

  stageReg #(.payloadT(ctrlPkg::execPayloadT)) execRegE (
    .clk(clk), .rstN(rstN), .stall(stallE), .flush(flushE), .d(execD), .q(execE)
  );

  // ========================================
  // Execute
  // ========================================
  assign aluSrcE     = execE.aluSrc;
  assign aluControlE = execE.aluControl;

  executeCtrl execCtrlE (
    .flagsE        (flagsE),
    .aluFlagsE     (aluFlagsE),
    .addrLowE      (addrLowE),
    .flagWriteE    (execE.flagWrite),
    .branchE       (execE.branch),
    .memWriteE     (execE.memWrite),
    .memToRegE     (execE.memToReg),
    .regWriteE     (execE.regWrite),
    .pcWriteE      (execE.pcWrite),
    .byteAccessE   (execE.byteAccess),
    .condE         (execE.cond),
    .branchTakenE  (branchTakenE),
    .memWriteGated (memWriteGatedE),
    .regWriteGated (regWriteGatedE),
    .pcSrcGated    (pcSrcGatedE),
    .setFlags      (setFlagsE),
    .nextFlags     (nextFlagsE),
    .byteMask      (byteMaskE)
  );

  assign memE = '{memWrite: memWriteGatedE, memToReg: execE.memToReg,
                  regWrite: regWriteGatedE, pcSrc: pcSrcGatedE, byteMask: byteMaskE,
                  setFlags: setFlagsE, nextFlags: nextFlagsE};

  stageReg #(.payloadT(ctrlPkg::memPayloadT)) memRegM (
    .clk(clk), .rstN(rstN), .stall(stallM), .flush(flushM), .d(memE), .q(memM)
  );

  // ========================================
  // Memory and Writeback
  // ========================================
  assign memWriteM = memM.memWrite;
  assign memToRegM = memM.memToReg;
  assign byteMaskM = memM.byteMask;

  assign wbM = '{memToReg: memM.memToReg, regWrite: memM.regWrite, pcSrc: memM.pcSrc,
                 setFlags: memM.setFlags, nextFlags: memM.nextFlags};

  stageReg #(.payloadT(ctrlPkg::wbPayloadT)) wbRegW (
    .clk(clk), .rstN(rstN), .stall(stallW), .flush(flushW), .d(wbM), .q(wbW)
  );

  assign regWriteW = wbW.regWrite;
  assign memToRegW = wbW.memToReg;
  assign pcSrcW    = wbW.pcSrc;

  // Committed flags plus M/W forwarding back to Execute
  statusReg statusRegW (
    .clk        (clk),
    .rstN       (rstN),
    .stallW     (stallW),
    .setFlagsM  (memM.setFlags),
    .nextFlagsM (memM.nextFlags),
    .setFlagsW  (wbW.setFlags),
    .nextFlagsW (wbW.nextFlags),
    .flagsE     (flagsE)
  );

endmodule

// File: src/condUnit.sv
`timescale 1ns/1ps

module condUnit (
  input  isaPkg::condT        cond,
  input  isaPkg::flagsT       flags,      // Current NZCV, forwarded
  input  isaPkg::flagsT       aluFlags,   // Result flags of this instr
  input  ctrlPkg::flagWriteT  flagWrite,
  output logic                condEx,
  output isaPkg::flagsT       nextFlags
);

  logic n, z, c, v;
  logic ge;  // Signed greater or equal

  assign n  = flags[isaPkg::flagN];
  assign z  = flags[isaPkg::flagZ];
  assign c  = flags[isaPkg::flagC];
  assign v  = flags[isaPkg::flagV];
  assign ge = (n == v);

  // ========================================
  // Condition check
  // ========================================
  always_comb begin
    unique case (cond)
      isaPkg::condEq: condEx = z;
      isaPkg::condNe: condEx = ~z;
      isaPkg::condCs: condEx = c;
      isaPkg::condCc: condEx = ~c;
      isaPkg::condMi: condEx = n;
      isaPkg::condPl: condEx = ~n;
      isaPkg::condVs: condEx = v;
      isaPkg::condVc: condEx = ~v;
      isaPkg::condHi: condEx = c & ~z;     // Unsigned higher
      isaPkg::condLs: condEx = ~c | z;
      isaPkg::condGe: condEx = ge;
      isaPkg::condLt: condEx = ~ge;
      isaPkg::condGt: condEx = ~z & ge;
      isaPkg::condLe: condEx = z | ~ge;
      isaPkg::condAl: condEx = 1'b1;
      isaPkg::condNv: condEx = 1'b0;       // Reserved encoding
    endcase
  end

  // Per group flag update, unwritten flags carry through
  always_comb begin
    nextFlags = flags;
    if (flagWrite[ctrlPkg::flagWriteNz]) begin
      nextFlags[isaPkg::flagN] = aluFlags[isaPkg::flagN];
      nextFlags[isaPkg::flagZ] = aluFlags[isaPkg::flagZ];
    end
    if (flagWrite[ctrlPkg::flagWriteCv]) begin
      nextFlags[isaPkg::flagC] = aluFlags[isaPkg::flagC];
      nextFlags[isaPkg::flagV] = aluFlags[isaPkg::flagV];
    end
  end

endmodule

// File: src/ctrlPkg.sv
package ctrlPkg;

  // ========================================
  // Decode stage selects
  // ========================================
  typedef logic [1:0] regSrcT;
  localparam int regSrcPc = 0;  // First operand from PC (branch)
  localparam int regSrcRd = 1;  // Second operand from Rd (store data)

  // Immediate extension select
  typedef enum logic [1:0] {
    immDp     = 2'b00,  // 8 bit rotated
    immMem    = 2'b01,  // 12 bit offset
    immBranch = 2'b10   // 24 bit word offset
  } immSrcT;

  // Flag write request, NZ and CV separately
  typedef logic [1:0] flagWriteT;
  localparam int flagWriteNz = 1;
  localparam int flagWriteCv = 0;

  // One bit per byte lane, lane 0 lowest byte
  typedef logic [3:0] byteMaskT;
  localparam byteMaskT maskWord = 4'b1111;

  // ========================================
  // Stage payloads
  // ========================================
  typedef struct packed {
    logic              aluSrc;      // Immediate as operand B
    isaPkg::aluOpT     aluControl;
    flagWriteT         flagWrite;
    logic              branch;
    logic              memWrite;
    logic              memToReg;
    logic              regWrite;
    logic              pcWrite;     // Writes R15, branch or load
    logic              byteAccess;
    isaPkg::condT      cond;
  } execPayloadT;

  // Everything here is already gated by the condition check
  typedef struct packed {
    logic              memWrite;
    logic              memToReg;
    logic              regWrite;
    logic              pcSrc;
    byteMaskT          byteMask;
    logic              setFlags;
    isaPkg::flagsT     nextFlags;
  } memPayloadT;

  typedef struct packed {
    logic              memToReg;
    logic              regWrite;
    logic              pcSrc;
    logic              setFlags;
    isaPkg::flagsT     nextFlags;
  } wbPayloadT;

endpackage

// File: src/executeCtrl.sv
`timescale 1ns/1ps

module executeCtrl (
  input  isaPkg::flagsT       flagsE,      // Forwarded NZCV
  input  isaPkg::flagsT       aluFlagsE,
  input  logic [1:0]          addrLowE,    // Byte offset of the address
  // Execute payload fields
  input  ctrlPkg::flagWriteT  flagWriteE,
  input  logic                branchE,
  input  logic                memWriteE,
  input  logic                memToRegE,
  input  logic                regWriteE,
  input  logic                pcWriteE,
  input  logic                byteAccessE,
  input  isaPkg::condT        condE,
  // Gated results for the Memory stage
  output logic                branchTakenE,
  output logic                memWriteGated,
  output logic                regWriteGated,
  output logic                pcSrcGated,
  output logic                setFlags,
  output isaPkg::flagsT       nextFlags,
  output ctrlPkg::byteMaskT   byteMask
);

  logic               condEx;
  logic               memAccess;  // Load or store in Execute
  ctrlPkg::byteMaskT  laneMask;   // One hot lane for byte access

  condUnit condUnitE (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (flagWriteE),
    .condEx    (condEx),
    .nextFlags (nextFlags)
  );

  // ========================================
  // Condition gating
  // ========================================
  // A failed condition turns the instruction into a no-op
  assign branchTakenE  = branchE & condEx;
  assign memWriteGated = memWriteE & condEx;
  assign regWriteGated = regWriteE & condEx;
  assign pcSrcGated    = pcWriteE & condEx;
  assign setFlags      = (flagWriteE != '0) & condEx;

  // ========================================
  // Store byte lanes
  // ========================================
  assign memAccess = memWriteE | memToRegE;
  assign laneMask  = ctrlPkg::byteMaskT'(1) << addrLowE;

  always_comb begin
    if (!memAccess) begin
      byteMask = '0;                  // No memory traffic
    end else if (byteAccessE) begin
      byteMask = laneMask;
    end else begin
      byteMask = ctrlPkg::maskWord;   // Full word
    end
  end

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  isaPkg::instrT       instrD,
  // Decode stage selects for the datapath
  output ctrlPkg::regSrcT     regSrcD,
  output ctrlPkg::immSrcT     immSrcD,
  // Controls carried on to Execute
  output logic                aluSrcD,
  output isaPkg::aluOpT       aluControlD,
  output ctrlPkg::flagWriteT  flagWriteD,
  output logic                branchD,
  output logic                memWriteD,
  output logic                memToRegD,
  output logic                regWriteD,
  output logic                pcWriteD,
  output logic                byteAccessD
);

  isaPkg::classT  instrClass;
  isaPkg::aluOpT  opcodeD;
  isaPkg::regT    rdD;
  logic           immD;       // I bit
  logic           upD;        // U bit
  logic           byteD;      // B bit
  logic           loadD;      // L bit
  logic           setFlagsD;  // S bit
  logic           testOpD;    // TST/TEQ/CMP/CMN, flags only

  // ========================================
  // Field extraction
  // ========================================
  assign instrClass = isaPkg::classT'(instrD[isaPkg::classField +: $bits(isaPkg::classT)]);
  assign opcodeD    = isaPkg::aluOpT'(instrD[isaPkg::opcodeField +: $bits(isaPkg::aluOpT)]);
  assign rdD        = instrD[isaPkg::rdField +: $bits(isaPkg::regT)];
  assign immD       = instrD[isaPkg::immBit];
  assign upD        = instrD[isaPkg::upBit];
  assign byteD      = instrD[isaPkg::byteBit];
  assign loadD      = instrD[isaPkg::loadBit];
  assign setFlagsD  = instrD[isaPkg::setFlagsBit];

  // Compare/test group has opcode 10xx
  assign testOpD = opcodeD inside {isaPkg::aluTst, isaPkg::aluTeq,
                                   isaPkg::aluCmp, isaPkg::aluCmn};

  // ========================================
  // Main control decode
  // ========================================
  always_comb begin
    // Everything off unless a class turns it on
    regSrcD     = '0;
    immSrcD     = ctrlPkg::immDp;
    aluSrcD     = 1'b0;
    aluControlD = isaPkg::aluAnd;
    flagWriteD  = '0;
    branchD     = 1'b0;
    memWriteD   = 1'b0;
    memToRegD   = 1'b0;
    regWriteD   = 1'b0;
    byteAccessD = 1'b0;

    unique case (instrClass)
      isaPkg::clsDataProc: begin
        aluControlD = opcodeD;         // Opcode drives ALU directly
        aluSrcD     = immD;            // Rotated imm or Rm
        regWriteD   = ~testOpD;        // Compares only touch flags
        flagWriteD  = {2{setFlagsD}};  // S sets both NZ and CV
      end

      isaPkg::clsMem: begin
        immSrcD     = ctrlPkg::immMem;
        aluSrcD     = ~immD;           // I clear means 12 bit offset
        aluControlD = upD ? isaPkg::aluAdd : isaPkg::aluSub;
        byteAccessD = byteD;
        if (loadD) begin
          memToRegD = 1'b1;
          regWriteD = 1'b1;
        end else begin
          memWriteD = 1'b1;
          regSrcD[ctrlPkg::regSrcRd] = 1'b1;  // Store data comes from Rd
        end
      end

      isaPkg::clsBranch: begin
        branchD     = 1'b1;
        regSrcD[ctrlPkg::regSrcPc] = 1'b1;  // Target is PC relative
        immSrcD     = ctrlPkg::immBranch;
        aluSrcD     = 1'b1;
        aluControlD = isaPkg::aluAdd;
      end

      default: ;  // Class 11 undefined, all zero
    endcase
  end

  // Any write to R15 redirects fetch
  assign pcWriteD = (regWriteD && (rdD == isaPkg::pcReg)) || branchD;

endmodule

// File: src/isaPkg.sv
package isaPkg;

  // ========================================
  // Raw word types
  // ========================================
  typedef logic [31:0] instrT;  // Instruction word as fetched
  typedef logic [3:0]  regT;    // Register number
  typedef logic [3:0]  flagsT;  // NZCV, N on top

  // Bit index of each flag inside flagsT
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  localparam regT pcReg = 4'd15;  // R15 reads as PC

  // ========================================
  // Field positions, lsb of each field
  // ========================================
  localparam int condField   = 28;  // [31:28]
  localparam int classField  = 26;  // [27:26]
  localparam int immBit      = 25;  // I, operand 2 / offset kind
  localparam int opcodeField = 21;  // [24:21] DP opcode
  localparam int upBit       = 23;  // U, add or subtract offset
  localparam int byteBit     = 22;  // B, byte or word
  localparam int loadBit     = 20;  // L on load/store
  localparam int setFlagsBit = 20;  // S on data processing, shares L
  localparam int rdField     = 12;  // [15:12]

  // Top level instruction classes, bits 27:26
  typedef enum logic [1:0] {
    clsDataProc = 2'b00,
    clsMem      = 2'b01,
    clsBranch   = 2'b10,
    clsUndef    = 2'b11   // Coprocessor, SWI etc, not handled
  } classT;

  // Condition codes in ARM order
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl,
    condNv  // Reserved, never executes
  } condT;

  // DP opcodes double as ALU control
  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb, aluAdd, aluAdc, aluSbc, aluRsc,
    aluTst, aluTeq, aluCmp, aluCmn, aluOrr, aluMov, aluBic, aluMvn
  } aluOpT;

endpackage

// File: src/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = ctrlPkg::execPayloadT
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     stall,  // Hold current contents
  input  logic     flush,  // Insert bubble, wins over stall
  input  payloadT  d,
  output payloadT  q
);

  // Bubble is the all zero payload, same as reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// File: src/statusReg.sv
`timescale 1ns/1ps

module statusReg (
  input  logic           clk,
  input  logic           rstN,
  input  logic           stallW,
  // Flag results still in flight
  input  logic           setFlagsM,
  input  isaPkg::flagsT  nextFlagsM,
  input  logic           setFlagsW,
  input  isaPkg::flagsT  nextFlagsW,
  output isaPkg::flagsT  flagsE      // Flags seen by the Execute check
);

  isaPkg::flagsT flagsQ;  // Committed NZCV

  // Commit from Writeback unless it is held
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (setFlagsW && !stallW) begin
      flagsQ <= nextFlagsW;
    end
  end

  // ========================================
  // Forwarding, youngest writer first
  // ========================================
  always_comb begin
    if (setFlagsM) begin
      flagsE = nextFlagsM;
    end else if (setFlagsW) begin
      flagsE = nextFlagsW;
    end else begin
      flagsE = flagsQ;
    end
  end

endmodule
